// ==== verilog/cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// line size in bits, 32 bytes per line
`define LINE_BITS 256

// number of sets, direct mapped
`define NUM_SETS 16

// address split derived from line size and set count
`define OFFSET_BITS $clog2(`LINE_BITS / 8)
`define INDEX_BITS $clog2(`NUM_SETS)
`define TAG_BITS (32 - `INDEX_BITS - `OFFSET_BITS)

`endif

// ==== verilog/rv32i_types.sv ====
package rv32i_types;

	// processor-facing types shared by the core side of both caches

	// one address or data word
	typedef logic [31:0] rv32i_word;

	// store byte lanes, bit i enables byte i of the word
	typedef logic [3:0] byte_en_t;

endpackage : rv32i_types

// ==== verilog/cache_types.sv ====
`include "cache_macros.svh"

package cache_types;

	// line and address field types
	typedef logic [`LINE_BITS-1:0] cache_line_t;
	typedef logic [`TAG_BITS-1:0] cache_tag_t;
	typedef logic [`INDEX_BITS-1:0] cache_index_t;
	// word select, byte offset bits without the low two
	typedef logic [`OFFSET_BITS-3:0] word_offset_t;

	// instruction cache control
	typedef enum logic [1:0] {
		ic_idle,
		ic_lookup,
		ic_fill
	} icache_state_t;

	// data cache control, write_back only on a dirty victim
	typedef enum logic [1:0] {
		dc_idle,
		dc_lookup,
		dc_write_back,
		dc_fill
	} dcache_state_t;

	// shared memory grant
	typedef enum logic [1:0] {
		arb_idle,
		arb_inst,
		arb_data
	} arb_state_t;

endpackage : cache_types

// ==== verilog/pmem_if.sv ====
`timescale 1ns/100ps

interface pmem_if
	import rv32i_types::*;
	import cache_types::*;
();

	// request side, driven by the cache
	logic read;
	logic write;
	rv32i_word address;
	cache_line_t wdata;

	// response side, resp is a single-cycle pulse
	cache_line_t rdata;
	logic resp;

	modport cache (
		output read, write, address, wdata,
		input rdata, resp
	);

	// mirror of the cache view
	modport arbiter (
		input read, write, address, wdata,
		output rdata, resp
	);

endinterface : pmem_if

// ==== verilog/icache.sv ====
`timescale 1ns/100ps

`include "cache_macros.svh"

module icache
	import rv32i_types::*;
	import cache_types::*;
(
	input logic clk,
	input logic reset,
	input logic read,
	input rv32i_word address,
	input logic advance,
	output rv32i_word rdata,
	output logic ready,
	pmem_if.cache mem
);

	icache_state_t state;
	icache_state_t state_next;

	// storage, one line per set
	cache_tag_t tag_array [`NUM_SETS];
	cache_line_t line_array [`NUM_SETS];
	logic [`NUM_SETS-1:0] valid_array;

	cache_tag_t addr_tag;
	cache_index_t addr_index;
	word_offset_t addr_word;
	cache_line_t line;
	logic hit;

	// split the fetch address
	assign addr_tag = address[31 -: `TAG_BITS];
	assign addr_index = address[`OFFSET_BITS +: `INDEX_BITS];
	assign addr_word = address[`OFFSET_BITS-1:2];

	assign line = line_array[addr_index];
	assign hit = valid_array[addr_index] && (tag_array[addr_index] == addr_tag);

	// selected word, stable while the line sits unchanged
	assign rdata = line[addr_word*32 +: 32];

	// fill request, line aligned
	assign mem.read = (state == ic_fill);
	// read-only cache, never writes back
	assign mem.write = 1'b0;
	assign mem.wdata = '0;
	assign mem.address = {addr_tag, addr_index, {`OFFSET_BITS{1'b0}}};

	// ready when nothing asked, or a hit waits for advance
	always_comb begin
		case (state)
			ic_idle: ready = !read;
			ic_lookup: ready = hit;
			default: ready = 1'b0;
		endcase
	end

	always_comb begin
		state_next = state;
		case (state)
			ic_idle: begin
				// lookup happens the cycle after the request
				if (read)
					state_next = ic_lookup;
			end
			ic_lookup: begin
				if (!hit)
					state_next = ic_fill;
				else if (advance)
					state_next = ic_idle;
			end
			ic_fill: begin
				// back to lookup, which then hits
				if (mem.resp)
					state_next = ic_lookup;
			end
			default: state_next = ic_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= ic_idle;
		else
			state <= state_next;
	end

	// all lines invalid out of reset
	always_ff @(posedge clk) begin
		if (reset)
			valid_array <= '0;
		else if (state == ic_fill && mem.resp)
			valid_array[addr_index] <= 1'b1;
	end

	// line and tag written on the fill response
	always_ff @(posedge clk) begin
		if (state == ic_fill && mem.resp) begin
			line_array[addr_index] <= mem.rdata;
			tag_array[addr_index] <= addr_tag;
		end
	end

endmodule : icache

// ==== verilog/dcache.sv ====
`timescale 1ns/100ps

`include "cache_macros.svh"

module dcache
	import rv32i_types::*;
	import cache_types::*;
(
	input logic clk,
	input logic reset,
	input logic read,
	input logic write,
	input rv32i_word address,
	input rv32i_word wdata,
	input byte_en_t byte_enable,
	input logic advance,
	output rv32i_word rdata,
	output logic ready,
	pmem_if.cache mem
);

	dcache_state_t state;
	dcache_state_t state_next;

	// storage, one line per set
	cache_tag_t tag_array [`NUM_SETS];
	cache_line_t line_array [`NUM_SETS];
	logic [`NUM_SETS-1:0] valid_array;
	logic [`NUM_SETS-1:0] dirty_array;

	cache_tag_t addr_tag;
	cache_index_t addr_index;
	word_offset_t addr_word;
	cache_line_t line;
	cache_line_t line_merged;
	logic hit;
	logic victim_dirty;
	logic store_en;
	logic fill_done;

	// split the data address
	assign addr_tag = address[31 -: `TAG_BITS];
	assign addr_index = address[`OFFSET_BITS +: `INDEX_BITS];
	assign addr_word = address[`OFFSET_BITS-1:2];

	assign line = line_array[addr_index];
	assign hit = valid_array[addr_index] && (tag_array[addr_index] == addr_tag);
	assign victim_dirty = valid_array[addr_index] && dirty_array[addr_index];

	// load data straight from the line
	assign rdata = line[addr_word*32 +: 32];

	// store commits once, in the cycle the pipeline moves on
	assign store_en = (state == dc_lookup) && hit && write && advance;
	assign fill_done = (state == dc_fill) && mem.resp;

	// byte lane merge of the store word into the line
	always_comb begin
		line_merged = line;
		for (int i = 0; i < 4; i++) begin
			if (byte_enable[i])
				line_merged[addr_word*32 + i*8 +: 8] = wdata[i*8 +: 8];
		end
	end

	// memory channel
	assign mem.read = (state == dc_fill);
	assign mem.write = (state == dc_write_back);
	assign mem.wdata = line;
	// victim address rebuilt from the stored tag
	always_comb begin
		if (state == dc_write_back)
			mem.address = {tag_array[addr_index], addr_index, {`OFFSET_BITS{1'b0}}};
		else
			mem.address = {addr_tag, addr_index, {`OFFSET_BITS{1'b0}}};
	end

	// ready when idle and unused, or a hit is held
	always_comb begin
		case (state)
			dc_idle: ready = !(read || write);
			dc_lookup: ready = hit;
			default: ready = 1'b0;
		endcase
	end

	always_comb begin
		state_next = state;
		case (state)
			dc_idle: begin
				if (read || write)
					state_next = dc_lookup;
			end
			dc_lookup: begin
				// dirty victim goes out before the fill
				if (!hit)
					state_next = victim_dirty ? dc_write_back : dc_fill;
				else if (advance)
					state_next = dc_idle;
			end
			dc_write_back: begin
				if (mem.resp)
					state_next = dc_fill;
			end
			dc_fill: begin
				if (mem.resp)
					state_next = dc_lookup;
			end
			default: state_next = dc_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= dc_idle;
		else
			state <= state_next;
	end

	// valid and dirty, cleared on reset
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_array <= '0;
			dirty_array <= '0;
		end else if (fill_done) begin
			valid_array[addr_index] <= 1'b1;
			dirty_array[addr_index] <= 1'b0;
		end else if (store_en) begin
			dirty_array[addr_index] <= 1'b1;
		end
	end

	// line data from a fill or a store merge
	always_ff @(posedge clk) begin
		if (fill_done) begin
			line_array[addr_index] <= mem.rdata;
			tag_array[addr_index] <= addr_tag;
		end else if (store_en) begin
			line_array[addr_index] <= line_merged;
		end
	end

endmodule : dcache

// ==== verilog/arbiter.sv ====
`timescale 1ns/100ps

module arbiter
	import rv32i_types::*;
	import cache_types::*;
(
	input logic clk,
	input logic reset,
	pmem_if.arbiter inst,
	pmem_if.arbiter data,
	output logic pmem_read,
	output logic pmem_write,
	output rv32i_word pmem_address,
	output cache_line_t pmem_wdata,
	input cache_line_t pmem_rdata,
	input logic pmem_resp
);

	arb_state_t state;
	arb_state_t state_next;

	logic inst_req;
	logic data_req;
	logic sel_inst;

	assign inst_req = inst.read || inst.write;
	assign data_req = data.read || data.write;

	// idle picks by priority so the request reaches memory
	// in the same cycle, afterwards the held grant decides
	assign sel_inst = (state == arb_inst) || (state == arb_idle && inst_req);

	// request mux toward memory
	always_comb begin
		if (sel_inst) begin
			pmem_read = inst.read;
			pmem_write = inst.write;
			pmem_address = inst.address;
			pmem_wdata = inst.wdata;
		end else begin
			pmem_read = data.read;
			pmem_write = data.write;
			pmem_address = data.address;
			pmem_wdata = data.wdata;
		end
	end

	// responses only to the side holding the grant
	assign inst.resp = pmem_resp && (state == arb_inst);
	assign data.resp = pmem_resp && (state == arb_data);
	assign inst.rdata = (state == arb_inst) ? pmem_rdata : '0;
	assign data.rdata = (state == arb_data) ? pmem_rdata : '0;

	always_comb begin
		state_next = state;
		case (state)
			arb_idle: begin
				// instruction side first
				if (inst_req)
					state_next = arb_inst;
				else if (data_req)
					state_next = arb_data;
			end
			arb_inst, arb_data: begin
				// grant ends with the transaction
				if (pmem_resp)
					state_next = arb_idle;
			end
			default: state_next = arb_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= arb_idle;
		else
			state <= state_next;
	end

endmodule : arbiter

// ==== verilog/mem_hier.sv ====
`timescale 1ns/100ps

module mem_hier
	import rv32i_types::*;
	import cache_types::*;
(
	input logic clk,
	input logic reset,

	// shared line memory
	output logic pmem_read,
	output logic pmem_write,
	output rv32i_word pmem_address,
	output cache_line_t pmem_wdata,
	input cache_line_t pmem_rdata,
	input logic pmem_resp,

	// fetch side of the core
	input logic inst_read,
	input rv32i_word inst_addr,
	output rv32i_word inst_rdata,

	// load/store side of the core
	input logic mem_read,
	input logic mem_write,
	input rv32i_word mem_address,
	input rv32i_word mem_wdata,
	input byte_en_t mem_byte_enable,
	output rv32i_word mem_rdata,

	output logic pipeline_advance
);

	logic inst_ready;
	logic data_ready;

	// cache to arbiter channels
	pmem_if inst_mem();
	pmem_if data_mem();

	// pipeline moves only when both sides are done
	assign pipeline_advance = inst_ready && data_ready;

	icache icache (
		.clk (clk),
		.reset (reset),
		.read (inst_read),
		.address (inst_addr),
		.advance (pipeline_advance),
		.rdata (inst_rdata),
		.ready (inst_ready),
		.mem (inst_mem)
	);

	dcache dcache (
		.clk (clk),
		.reset (reset),
		.read (mem_read),
		.write (mem_write),
		.address (mem_address),
		.wdata (mem_wdata),
		.byte_enable (mem_byte_enable),
		.advance (pipeline_advance),
		.rdata (mem_rdata),
		.ready (data_ready),
		.mem (data_mem)
	);

	arbiter arbiter (
		.clk (clk),
		.reset (reset),
		.inst (inst_mem),
		.data (data_mem),
		.pmem_read (pmem_read),
		.pmem_write (pmem_write),
		.pmem_address (pmem_address),
		.pmem_wdata (pmem_wdata),
		.pmem_rdata (pmem_rdata),
		.pmem_resp (pmem_resp)
	);

endmodule : mem_hier

// ==== dv/pmem_model.sv ====
`timescale 1ns/100ps

`include "cache_macros.svh"

module pmem_model
	import rv32i_types::*;
	import cache_types::*;
(
	input logic clk,
	input logic reset,
	input logic read,
	input logic write,
	input rv32i_word address,
	input cache_line_t wdata,
	output cache_line_t rdata,
	output logic resp
);

	// cycles from a seen request to its resp pulse
	localparam int latency = 4;
	localparam int line_addr_bits = 8;
	localparam int num_lines = 1 << line_addr_bits;

	cache_line_t lines [num_lines];
	int count;

	// each word holds its byte address xor 32'h5a5a_0000
	initial begin
		for (int l = 0; l < num_lines; l++) begin
			for (int w = 0; w < 8; w++)
				lines[l][w*32 +: 32] = (l*32 + w*4) ^ 32'h5a5a_0000;
		end
	end

	always @(posedge clk) begin
		if (reset) begin
			count <= 0;
			resp <= 1'b0;
		end else begin
			resp <= 1'b0;
			// request still high in its resp cycle, do not count it again
			if ((read || write) && !resp) begin
				if (count == latency - 1) begin
					count <= 0;
					resp <= 1'b1;
					rdata <= lines[address[`OFFSET_BITS +: line_addr_bits]];
					if (write)
						lines[address[`OFFSET_BITS +: line_addr_bits]] <= wdata;
				end else begin
					count <= count + 1;
				end
			end
		end
	end

endmodule : pmem_model

// ==== dv/mem_hier_tb.sv ====
`timescale 1ns/100ps

module mem_hier_tb
	import rv32i_types::*;
	import cache_types::*;
();

	// core accesses over all tests, each gets 20 cycles
	localparam int num_transactions = 209;
	localparam int ref_words = 2048;

	logic clk;
	logic reset;
	logic pmem_read;
	logic pmem_write;
	rv32i_word pmem_address;
	cache_line_t pmem_wdata;
	cache_line_t pmem_rdata;
	logic pmem_resp;
	logic inst_read;
	rv32i_word inst_addr;
	rv32i_word inst_rdata;
	logic mem_read;
	logic mem_write;
	rv32i_word mem_address;
	rv32i_word mem_wdata;
	byte_en_t mem_byte_enable;
	rv32i_word mem_rdata;
	logic pipeline_advance;

	// word level copy of what memory plus caches should hold
	rv32i_word ref_mem [ref_words];

	// pmem transaction record, updated on each resp
	int txn_count = 0;
	int wb_seq = 0;
	int fill_seq = 0;
	rv32i_word wb_addr;
	rv32i_word fill_addr;
	cache_line_t wb_line;

	// open request on the pmem port, as first seen
	logic req_open;
	logic held_read;
	logic held_write;
	rv32i_word held_address;

	mem_hier mem_hier_i (.*);

	pmem_model pmem_model_i (
		.clk (clk),
		.reset (reset),
		.read (pmem_read),
		.write (pmem_write),
		.address (pmem_address),
		.wdata (pmem_wdata),
		.rdata (pmem_rdata),
		.resp (pmem_resp)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_word(input string name, input rv32i_word expected,
		input rv32i_word actual);
		if (actual !== expected)
			stop_on_error($sformatf("** Error %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	task automatic check_line(input string name, input cache_line_t expected,
		input cache_line_t actual);
		if (actual !== expected)
			stop_on_error($sformatf("** Error %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	function automatic rv32i_word merge_bytes(input rv32i_word old, input rv32i_word wd,
		input byte_en_t be);
		rv32i_word result;
		result = old;
		for (int i = 0; i < 4; i++) begin
			if (be[i])
				result[i*8 +: 8] = wd[i*8 +: 8];
		end
		return result;
	endfunction

	// expected line rebuilt from the word copy
	function automatic cache_line_t ref_line(input rv32i_word a);
		cache_line_t result;
		for (int w = 0; w < 8; w++)
			result[w*32 +: 32] = ref_mem[(a >> 2) - ((a >> 2) % 8) + w];
		return result;
	endfunction

	// one core cycle group, held until pipeline_advance
	task automatic core_access(input logic do_fetch, input rv32i_word iaddr, input logic do_load,
		input logic do_store, input rv32i_word daddr, input rv32i_word wd, input byte_en_t be,
		output rv32i_word irdata, output rv32i_word drdata);
		@(posedge clk);
		inst_read <= do_fetch;
		inst_addr <= iaddr;
		mem_read <= do_load;
		mem_write <= do_store;
		mem_address <= daddr;
		mem_wdata <= wd;
		mem_byte_enable <= be;
		do
			@(posedge clk);
		while (!pipeline_advance);
		irdata = inst_rdata;
		drdata = mem_rdata;
		inst_read <= 1'b0;
		mem_read <= 1'b0;
		mem_write <= 1'b0;
	endtask

	task automatic fetch_word(input rv32i_word a, output rv32i_word d);
		rv32i_word unused;
		core_access(1'b1, a, 1'b0, 1'b0, '0, '0, '0, d, unused);
	endtask

	task automatic load_word(input rv32i_word a, output rv32i_word d);
		rv32i_word unused;
		core_access(1'b0, '0, 1'b1, 1'b0, a, '0, '0, unused, d);
	endtask

	task automatic store_word(input rv32i_word a, input rv32i_word wd, input byte_en_t be);
		rv32i_word unused_i;
		rv32i_word unused_d;
		core_access(1'b0, '0, 1'b0, 1'b1, a, wd, be, unused_i, unused_d);
		ref_mem[a >> 2] = merge_bytes(ref_mem[a >> 2], wd, be);
	endtask

	task automatic expect_txns(input string name, input int start, input int n);
		if (txn_count - start != n)
			stop_on_error($sformatf("** Error %s: expected %0d memory transactions, actual %0d",
				name, n, txn_count - start));
	endtask

	task automatic fetch_test();
		rv32i_word d;
		int start;
		start = txn_count;
		fetch_word(32'h0000_1040, d);
		check_word("fetch_test", ref_mem[32'h1040 >> 2], d);
		expect_txns("fetch_test cold fetch", start, 1);
		// same line, must hit
		fetch_word(32'h0000_1048, d);
		check_word("fetch_test", ref_mem[32'h1048 >> 2], d);
		expect_txns("fetch_test neighbor fetch", start, 1);
	endtask

	task automatic load_test();
		rv32i_word d;
		int start;
		start = txn_count;
		load_word(32'h0000_0120, d);
		check_word("load_test", ref_mem[32'h0120 >> 2], d);
		load_word(32'h0000_012c, d);
		check_word("load_test", ref_mem[32'h012c >> 2], d);
		expect_txns("load_test", start, 1);
	endtask

	task automatic store_test();
		rv32i_word d;
		store_word(32'h0000_0124, 32'hdead_beef, 4'b0101);
		load_word(32'h0000_0124, d);
		check_word("store_test", ref_mem[32'h0124 >> 2], d);
	endtask

	task automatic evict_test();
		rv32i_word d;
		int start;
		// index 0 for both, tags differ
		store_word(32'h0000_0204, 32'h1234_5678, 4'b1111);
		start = txn_count;
		load_word(32'h0000_0604, d);
		check_word("evict_test", ref_mem[32'h0604 >> 2], d);
		expect_txns("evict_test", start, 2);
		check_word("evict_test", 32'h0000_0200, wb_addr);
		check_line("evict_test", ref_line(32'h0000_0200), wb_line);
		check_word("evict_test", 32'h0000_0600, fill_addr);
		if (wb_seq >= fill_seq)
			stop_on_error("evict_test: the fill read came before the dirty write-back");
	endtask

	task automatic contention_test();
		rv32i_word di;
		rv32i_word dd;
		int start;
		start = txn_count;
		core_access(1'b1, 32'h0000_1100, 1'b1, 1'b0, 32'h0000_0340, '0, '0, di, dd);
		// advance seen only after both fills ended
		expect_txns("contention_test", start, 2);
		check_word("contention_test", ref_mem[32'h1100 >> 2], di);
		check_word("contention_test", ref_mem[32'h0340 >> 2], dd);
	endtask

	task automatic random_test();
		rv32i_word a;
		rv32i_word d;
		for (int n = 0; n < 200; n++) begin
			// 64 lines, 4 tags per set
			a = ($urandom_range(0, 63) << 5) | ($urandom_range(0, 7) << 2);
			if ($urandom_range(0, 1)) begin
				store_word(a, $urandom(), byte_en_t'($urandom_range(1, 15)));
			end else begin
				load_word(a, d);
				check_word("random_test", ref_mem[a >> 2], d);
			end
		end
	endtask

	// memory side monitor, one transaction on the port at a time
	always @(posedge clk) begin
		if (reset) begin
			req_open <= 1'b0;
		end else begin
			if (pmem_read && pmem_write)
				stop_on_error("pmem read and pmem write were high in the same cycle");
			// request must stay as first seen until its resp
			if (req_open && (pmem_read !== held_read || pmem_write !== held_write
				|| pmem_address !== held_address))
				stop_on_error("a pmem request changed before its response arrived");
			if (pmem_resp) begin
				req_open <= 1'b0;
				txn_count <= txn_count + 1;
				if (pmem_write) begin
					wb_addr <= pmem_address;
					wb_line <= pmem_wdata;
					wb_seq <= txn_count;
				end
				if (pmem_read) begin
					fill_addr <= pmem_address;
					fill_seq <= txn_count;
				end
			end else if (!req_open && (pmem_read || pmem_write)) begin
				req_open <= 1'b1;
				held_read <= pmem_read;
				held_write <= pmem_write;
				held_address <= pmem_address;
			end
		end
	end

	// watchdog
	initial begin
		repeat (16 + num_transactions * 20)
			@(posedge clk);
		stop_on_error("the run timed out before the tests finished");
	end

	initial begin
		void'($urandom(32'hc59e_51f3));
		reset = 1'b1;
		inst_read = 1'b0;
		inst_addr = '0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_address = '0;
		mem_wdata = '0;
		mem_byte_enable = '0;
		for (int i = 0; i < ref_words; i++)
			ref_mem[i] = (i * 4) ^ 32'h5a5a_0000;
		repeat (16)
			@(posedge clk);
		reset <= 1'b0;
		fetch_test();
		load_test();
		store_test();
		evict_test();
		contention_test();
		random_test();
		$display("No errors");
		$finish;
	end

endmodule : mem_hier_tb

// ==== mem_hier.f ====
+incdir+verilog
verilog/rv32i_types.sv
verilog/cache_types.sv
verilog/pmem_if.sv
verilog/icache.sv
verilog/dcache.sv
verilog/arbiter.sv
verilog/mem_hier.sv
dv/pmem_model.sv
dv/mem_hier_tb.sv

// ==== Bender.yml ====
package:
  name: mem_hier

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv32i_types.sv
      - verilog/cache_types.sv
      - verilog/pmem_if.sv
      - verilog/icache.sv
      - verilog/dcache.sv
      - verilog/arbiter.sv
      - verilog/mem_hier.sv
      - target: test
        files:
          - dv/pmem_model.sv
          - dv/mem_hier_tb.sv
